// ==== logic/udp_echo_frame_pkg.sv ====
`default_nettype none

// sizes of the UDP payload path between the MAC and the echo logic
package udp_echo_frame_pkg;

    // matches the MAC's udp_rx_len field
    localparam int LEN_W = 16;

    // MAC receive buffer is 2 KB, byte addressed
    localparam int ADDR_W = 11;

    // longest payload the echo path accepts
    localparam int MAX_PAYLOAD = 1024;

endpackage : udp_echo_frame_pkg

`default_nettype wire

// ==== logic/udp_echo_ctrl_pkg.sv ====
`default_nettype none

// phase of one echo, from receive to end of transmit
package udp_echo_ctrl_pkg;

    // idle: wait for fs_udp_rx
    // load: copy the MAC receive buffer into the FIFO
    // hold: fs_udp_tx up, wait for the MAC's request
    // send: stream the FIFO onto udp_txd
    typedef enum logic [1:0] {
        ph_idle = 2'd0,
        ph_load = 2'd1,
        ph_hold = 2'd2,
        ph_send = 2'd3
    } echo_phase_t;

endpackage : udp_echo_ctrl_pkg

`default_nettype wire

// ==== logic/payload_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 1024
) (
    input  wire                           sys_clk,
    input  wire                           rst,
    input  wire                           wr_en,
    input  wire  [7:0]                    wr_data,
    input  wire                           rd_en,
    output logic [7:0]                    rd_data,
    output logic [$clog2(FIFO_DEPTH):0]   level
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             empty;

    assign full  = (level == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (level == '0);

    // storage and registered read port
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // pointers wrap on their own, depth is a power of two
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // the loader and sender have no flow control, so the FIFO must never limit them
    a_no_overflow: assert property (@(posedge sys_clk) disable iff (rst) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge sys_clk) disable iff (rst) rd_en |-> !empty);

endmodule : payload_fifo

`default_nettype wire

// ==== logic/byte_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_counter (
    input  wire                                  sys_clk,
    input  wire                                  rst,
    input  wire                                  count_load,
    input  wire  [udp_echo_frame_pkg::LEN_W-1:0] count_len,
    input  wire                                  step,
    output logic [udp_echo_frame_pkg::ADDR_W-1:0] index,
    output logic                                 count_last,
    output logic                                 count_done
);

    // bytes still to move
    logic [udp_echo_frame_pkg::LEN_W-1:0] remaining;

    assign count_last = (remaining == udp_echo_frame_pkg::LEN_W'(1));
    assign count_done = step && count_last;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            remaining <= '0;
            index     <= '0;
        end else if (count_load) begin
            remaining <= count_len;
            index     <= '0;
        end else if (step) begin
            remaining <= remaining - 1'b1;
            index     <= index + 1'b1;
        end
    end

    // loader and sender must stop stepping once the count has run out
    a_no_step_when_empty: assert property (
        @(posedge sys_clk) disable iff (rst) step |-> (remaining != '0)
    );

endmodule : byte_counter

`default_nettype wire

// ==== logic/echo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_ctrl (
    input  wire                                   sys_clk,
    input  wire                                   rst,
    input  wire                                   fs_udp_rx,
    input  wire  [udp_echo_frame_pkg::LEN_W-1:0]  udp_rx_len,
    input  wire                                   flag_udp_tx_req,
    input  wire                                   fd_udp_tx,
    input  wire                                   count_done,
    input  wire                                   load_done,
    output udp_echo_ctrl_pkg::echo_phase_t        phase,
    output logic                                  count_load,
    output logic [udp_echo_frame_pkg::LEN_W-1:0]  count_len,
    output logic                                  fd_udp_rx,
    output logic                                  fs_udp_tx,
    output logic                                  flag_udp_tx_prep,
    output logic                                  len_err,
    output logic                                  echo_done,
    output logic [udp_echo_frame_pkg::LEN_W-1:0]  echo_len
);

    logic len_ok;
    logic rx_start;
    logic tx_grant;
    logic tx_sent;
    // the MAC may report fd_udp_tx as early as the last byte
    logic fd_seen;
    logic tx_finish;

    assign len_ok = (udp_rx_len != '0) &&
                    (udp_rx_len <= udp_echo_frame_pkg::LEN_W'(udp_echo_frame_pkg::MAX_PAYLOAD));
    assign rx_start  = (phase == udp_echo_ctrl_pkg::ph_idle) && fs_udp_rx;
    assign tx_grant  = (phase == udp_echo_ctrl_pkg::ph_hold) && flag_udp_tx_req;
    assign tx_finish = (phase == udp_echo_ctrl_pkg::ph_send) &&
                       (tx_sent || count_done) && (fd_seen || fd_udp_tx);

    // counter loads once per direction: fresh length on receive, latched one on send
    assign count_load = (rx_start && len_ok) || tx_grant;
    assign count_len  = tx_grant ? echo_len : udp_rx_len;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            phase            <= udp_echo_ctrl_pkg::ph_idle;
            echo_len         <= '0;
            fd_udp_rx        <= 1'b0;
            fs_udp_tx        <= 1'b0;
            flag_udp_tx_prep <= 1'b0;
            len_err          <= 1'b0;
            echo_done        <= 1'b0;
            tx_sent          <= 1'b0;
            fd_seen          <= 1'b0;
        end else begin
            // single-cycle strobes
            fd_udp_rx        <= 1'b0;
            flag_udp_tx_prep <= 1'b0;
            len_err          <= 1'b0;
            echo_done        <= 1'b0;
            case (phase)
                udp_echo_ctrl_pkg::ph_idle: begin
                    if (rx_start && len_ok) begin
                        echo_len <= udp_rx_len;
                        phase    <= udp_echo_ctrl_pkg::ph_load;
                    end else if (rx_start) begin
                        // bad length, acknowledge and drop
                        fd_udp_rx <= 1'b1;
                        len_err   <= 1'b1;
                    end
                end
                udp_echo_ctrl_pkg::ph_load: begin
                    if (load_done) begin
                        fd_udp_rx <= 1'b1;
                        fs_udp_tx <= 1'b1;
                        phase     <= udp_echo_ctrl_pkg::ph_hold;
                    end
                end
                udp_echo_ctrl_pkg::ph_hold: begin
                    if (tx_grant) begin
                        flag_udp_tx_prep <= 1'b1;
                        tx_sent          <= 1'b0;
                        fd_seen          <= 1'b0;
                        phase            <= udp_echo_ctrl_pkg::ph_send;
                    end
                end
                default: begin
                    if (count_done) begin
                        tx_sent <= 1'b1;
                    end
                    if (fd_udp_tx) begin
                        fd_seen <= 1'b1;
                    end
                    if (tx_finish) begin
                        fs_udp_tx <= 1'b0;
                        echo_done <= 1'b1;
                        phase     <= udp_echo_ctrl_pkg::ph_idle;
                    end
                end
            endcase
        end
    end

    // fs_udp_tx only spans hold and send
    a_tx_level_phase: assert property (
        @(posedge sys_clk) disable iff (rst)
        (phase == udp_echo_ctrl_pkg::ph_idle || phase == udp_echo_ctrl_pkg::ph_load)
            |-> !fs_udp_tx
    );

endmodule : echo_ctrl

`default_nettype wire

// ==== logic/payload_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_loader (
    input  wire                                   sys_clk,
    input  wire                                   rst,
    input  wire  udp_echo_ctrl_pkg::echo_phase_t  phase,
    input  wire  [udp_echo_frame_pkg::ADDR_W-1:0] index,
    input  wire                                   count_done,
    input  wire  [7:0]                            udp_rxd,
    output logic                                  step,
    output logic [udp_echo_frame_pkg::ADDR_W-1:0] udp_rx_addr,
    output logic                                  wr_en,
    output logic [7:0]                            wr_data,
    output logic                                  load_done
);

    logic in_load;
    // all addresses issued, only the last byte still returning
    logic stop_q;

    assign in_load     = (phase == udp_echo_ctrl_pkg::ph_load);
    assign step        = in_load && !stop_q;
    assign udp_rx_addr = index;
    // buffer data lines up with the delayed step
    assign wr_data     = udp_rxd;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            stop_q    <= 1'b0;
            wr_en     <= 1'b0;
            load_done <= 1'b0;
        end else begin
            wr_en     <= step;
            load_done <= in_load && count_done;
            if (!in_load) begin
                stop_q <= 1'b0;
            end else if (count_done) begin
                stop_q <= 1'b1;
            end
        end
    end

endmodule : payload_loader

`default_nettype wire

// ==== logic/payload_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_sender (
    input  wire                                  sys_clk,
    input  wire                                  rst,
    input  wire  udp_echo_ctrl_pkg::echo_phase_t phase,
    input  wire                                  count_done,
    input  wire  [7:0]                           rd_data,
    output logic                                 step,
    output logic                                 rd_en,
    output logic                                 udp_txen,
    output logic [7:0]                           udp_txd
);

    logic in_send;
    // low for the first send cycle, the prep cycle
    logic started;
    logic finished;

    assign in_send = (phase == udp_echo_ctrl_pkg::ph_send);
    assign rd_en   = in_send && started && !finished;
    assign step    = rd_en;

    // FIFO read data arrives with the registered valid, bus idles at zero
    assign udp_txd = udp_txen ? rd_data : 8'h00;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            started  <= 1'b0;
            finished <= 1'b0;
            udp_txen <= 1'b0;
        end else begin
            udp_txen <= rd_en;
            if (!in_send) begin
                started  <= 1'b0;
                finished <= 1'b0;
            end else begin
                started <= 1'b1;
                if (count_done) begin
                    finished <= 1'b1;
                end
            end
        end
    end

endmodule : payload_sender

`default_nettype wire

// ==== logic/activity_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
    parameter int LED_HOLD = 64
) (
    input  wire                                  sys_clk,
    input  wire                                  rst,
    input  wire                                  echo_done,
    input  wire  [udp_echo_frame_pkg::LEN_W-1:0] echo_len,
    output logic [3:0]                           led,
    output logic                                 lec
);

    localparam int HOLD_W = $clog2(LED_HOLD + 1);

    logic [HOLD_W-1:0] hold_cnt;

    // lit for exactly LED_HOLD cycles after each echo
    assign lec = (hold_cnt != '0);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            led      <= 4'h0;
            hold_cnt <= '0;
        end else if (echo_done) begin
            led      <= echo_len[3:0];
            hold_cnt <= HOLD_W'(LED_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

endmodule : activity_led

`default_nettype wire

// ==== logic/udp_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_echo_top #(
    parameter int FIFO_DEPTH = 1024,
    parameter int LED_HOLD   = 64
) (
    input  wire                                   sys_clk,
    input  wire                                   rst,
    input  wire                                   fs_udp_rx,
    input  wire  [udp_echo_frame_pkg::LEN_W-1:0]  udp_rx_len,
    input  wire  [7:0]                            udp_rxd,
    input  wire                                   flag_udp_tx_req,
    input  wire                                   fd_udp_tx,
    output logic                                  fd_udp_rx,
    output logic [udp_echo_frame_pkg::ADDR_W-1:0] udp_rx_addr,
    output logic                                  fs_udp_tx,
    output logic                                  flag_udp_tx_prep,
    output logic                                  udp_txen,
    output logic [7:0]                            udp_txd,
    output logic                                  len_err,
    output logic                                  lec,
    output logic [3:0]                            led
);

    udp_echo_ctrl_pkg::echo_phase_t       phase;
    logic                                 count_load;
    logic [udp_echo_frame_pkg::LEN_W-1:0] count_len;
    logic [udp_echo_frame_pkg::ADDR_W-1:0] index;
    logic                                 count_done;
    logic                                 load_step;
    logic                                 send_step;
    logic                                 step;
    logic                                 load_done;
    logic                                 echo_done;
    logic [udp_echo_frame_pkg::LEN_W-1:0] echo_len;
    logic                                 wr_en;
    logic [7:0]                           wr_data;
    logic                                 rd_en;
    logic [7:0]                           rd_data;
    logic [$clog2(FIFO_DEPTH):0]          fifo_level;

    // loader and sender step in exclusive phases
    assign step = load_step | send_step;

    echo_ctrl ctrl_i (
        .sys_clk(sys_clk), .rst(rst),
        .fs_udp_rx(fs_udp_rx), .udp_rx_len(udp_rx_len),
        .flag_udp_tx_req(flag_udp_tx_req), .fd_udp_tx(fd_udp_tx),
        .count_done(count_done), .load_done(load_done),
        .phase(phase), .count_load(count_load), .count_len(count_len),
        .fd_udp_rx(fd_udp_rx), .fs_udp_tx(fs_udp_tx),
        .flag_udp_tx_prep(flag_udp_tx_prep), .len_err(len_err),
        .echo_done(echo_done), .echo_len(echo_len)
    );

    byte_counter counter_i (
        .sys_clk(sys_clk), .rst(rst),
        .count_load(count_load), .count_len(count_len), .step(step),
        .index(index), .count_last(), .count_done(count_done)
    );

    payload_loader loader_i (
        .sys_clk(sys_clk), .rst(rst),
        .phase(phase), .index(index), .count_done(count_done), .udp_rxd(udp_rxd),
        .step(load_step), .udp_rx_addr(udp_rx_addr),
        .wr_en(wr_en), .wr_data(wr_data), .load_done(load_done)
    );

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .sys_clk(sys_clk), .rst(rst),
        .wr_en(wr_en), .wr_data(wr_data), .rd_en(rd_en),
        .rd_data(rd_data), .level(fifo_level)
    );

    payload_sender sender_i (
        .sys_clk(sys_clk), .rst(rst),
        .phase(phase), .count_done(count_done), .rd_data(rd_data),
        .step(send_step), .rd_en(rd_en), .udp_txen(udp_txen), .udp_txd(udp_txd)
    );

    activity_led #(.LED_HOLD(LED_HOLD)) led_i (
        .sys_clk(sys_clk), .rst(rst),
        .echo_done(echo_done), .echo_len(echo_len),
        .led(led), .lec(lec)
    );

    // a good receive leaves the whole payload in the FIFO
    a_fifo_holds_payload: assert property (
        @(posedge sys_clk) disable iff (rst)
        (fd_udp_rx && !len_err)
            |-> (udp_echo_frame_pkg::LEN_W'(fifo_level) == echo_len)
    );

endmodule : udp_echo_top

`default_nettype wire

// ==== verif/udp_echo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb;

    localparam int LED_HOLD    = 12;
    localparam int WAIT_LIMIT  = 64;
    localparam int MAX_PAYLOAD = udp_echo_frame_pkg::MAX_PAYLOAD;

    logic                                  sys_clk;
    logic                                  rst;
    logic                                  fs_udp_rx;
    logic [udp_echo_frame_pkg::LEN_W-1:0]  udp_rx_len;
    logic [7:0]                            udp_rxd = 8'h00;
    logic                                  flag_udp_tx_req;
    logic                                  fd_udp_tx;
    logic                                  fd_udp_rx;
    logic [udp_echo_frame_pkg::ADDR_W-1:0] udp_rx_addr;
    logic                                  fs_udp_tx;
    logic                                  flag_udp_tx_prep;
    logic                                  udp_txen;
    logic [7:0]                            udp_txd;
    logic                                  len_err;
    logic                                  lec;
    logic [3:0]                            led;

    // MAC receive buffer and the bytes expected back
    logic [7:0]  rx_buf [2048];
    logic [7:0]  ref_q [$];
    logic [31:0] rng_state;

    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int fd_rx_seen = 0;
    int len_err_seen = 0;
    int fd_rx_expected = 0;
    int len_err_expected = 0;

    udp_echo_top #(
        .FIFO_DEPTH(1024),
        .LED_HOLD(LED_HOLD)
    ) dut_i (
        .sys_clk(sys_clk), .rst(rst),
        .fs_udp_rx(fs_udp_rx), .udp_rx_len(udp_rx_len), .udp_rxd(udp_rxd),
        .flag_udp_tx_req(flag_udp_tx_req), .fd_udp_tx(fd_udp_tx),
        .fd_udp_rx(fd_udp_rx), .udp_rx_addr(udp_rx_addr), .fs_udp_tx(fs_udp_tx),
        .flag_udp_tx_prep(flag_udp_tx_prep), .udp_txen(udp_txen), .udp_txd(udp_txd),
        .len_err(len_err), .lec(lec), .led(led)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // receive buffer answers one cycle after the address
    always @(posedge sys_clk) begin
        udp_rxd <= rx_buf[udp_rx_addr];
    end

    // count the MAC side pulses as they happen
    always @(negedge sys_clk) begin
        if (fd_udp_rx) begin
            fd_rx_seen++;
        end
        if (len_err) begin
            len_err_seen++;
        end
    end

    // LCG step that keeps the upper bits since the low ones repeat quickly
    function automatic int rand_below(input int n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:8]) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s did not happen", $time, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic start_test();
        test_errors = 0;
        ref_q.delete();
    endtask

    task automatic finish_test(input string name);
        // pulses up to the last negedge are counted by now
        @(posedge sys_clk);
        check_value("fd_udp_rx pulses", 32'(fd_rx_seen), 32'(fd_rx_expected));
        check_value("len_err pulses", 32'(len_err_seen), 32'(len_err_expected));
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d mismatches", tests, name, test_errors);
        end
    endtask

    task automatic reject_bad_length(input int len);
        start_test();
        fd_rx_expected++;
        len_err_expected++;
        @(posedge sys_clk);
        fs_udp_rx  <= 1'b1;
        udp_rx_len <= udp_echo_frame_pkg::LEN_W'(len);
        @(posedge sys_clk);
        fs_udp_rx <= 1'b0;
        // dropped in the cycle right after the pulse
        @(negedge sys_clk);
        check_value("fd_udp_rx", 32'(fd_udp_rx), 32'd1);
        check_value("len_err", 32'(len_err), 32'd1);
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd0);
        @(negedge sys_clk);
        check_value("fd_udp_rx", 32'(fd_udp_rx), 32'd0);
        check_value("len_err", 32'(len_err), 32'd0);
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd0);
        finish_test($sformatf("bad length %0d", len));
    endtask

    task automatic echo_datagram(input int len, input bit poke_busy);
        int         i;
        int         cycles;
        int         waited;
        int         nbytes;
        int         lec_cycles;
        int         req_delay;
        int         fd_delay;
        logic [7:0] b;
        logic [7:0] expected;

        start_test();
        fd_rx_expected++;
        for (i = 0; i < len; i++) begin
            b = 8'(rand_below(256));
            rx_buf[udp_echo_frame_pkg::ADDR_W'(i)] = b;
            ref_q.push_back(b);
        end
        req_delay = rand_below(16);
        fd_delay  = rand_below(8);

        @(posedge sys_clk);
        fs_udp_rx  <= 1'b1;
        udp_rx_len <= udp_echo_frame_pkg::LEN_W'(len);
        @(posedge sys_clk);
        fs_udp_rx <= 1'b0;
        // one address per cycle counted from the fs_udp_rx pulse
        cycles = 0;
        do begin
            @(negedge sys_clk);
            cycles++;
            if (cycles <= len) begin
                check_value("udp_rx_addr", 32'(udp_rx_addr), 32'(cycles - 1));
            end
            if (!fd_udp_rx) begin
                check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd0);
            end
            if (cycles > len + WAIT_LIMIT) begin
                stop_on_timeout("fd_udp_rx after fs_udp_rx");
            end
        end while (!fd_udp_rx);
        check_value("fs_udp_rx to fd_udp_rx cycles", 32'(cycles), 32'(len + 2));
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd1);
        check_value("len_err", 32'(len_err), 32'd0);

        if (poke_busy) begin
            // a second datagram while busy is not taken
            @(posedge sys_clk);
            fs_udp_rx  <= 1'b1;
            udp_rx_len <= udp_echo_frame_pkg::LEN_W'(len);
            @(posedge sys_clk);
            fs_udp_rx <= 1'b0;
        end
        repeat (req_delay) begin
            @(negedge sys_clk);
            check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd1);
        end

        @(posedge sys_clk);
        flag_udp_tx_req <= 1'b1;
        waited = 0;
        @(negedge sys_clk);
        while (!flag_udp_tx_prep) begin
            if (waited == WAIT_LIMIT) begin
                stop_on_timeout("flag_udp_tx_prep after flag_udp_tx_req");
            end
            @(negedge sys_clk);
            waited++;
        end
        check_value("flag_udp_tx_req to flag_udp_tx_prep cycles", 32'(waited), 32'd1);
        @(posedge sys_clk);
        flag_udp_tx_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge sys_clk);
            waited++;
            // prep lasts a single cycle
            check_value("flag_udp_tx_prep", 32'(flag_udp_tx_prep), 32'd0);
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("udp_txen after flag_udp_tx_prep");
            end
        end while (!udp_txen);
        check_value("flag_udp_tx_prep to udp_txen cycles", 32'(waited), 32'd2);

        nbytes = 0;
        while (udp_txen) begin
            if (ref_q.size() > 0) begin
                expected = ref_q.pop_front();
                check_value("udp_txd", 32'(udp_txd), 32'(expected));
            end
            check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd1);
            nbytes++;
            if (nbytes > len + WAIT_LIMIT) begin
                stop_on_timeout("end of udp_txen");
            end
            @(negedge sys_clk);
        end
        check_value("udp_txen byte count", 32'(nbytes), 32'(len));

        // MAC reports the frame sent after a random delay
        repeat (fd_delay) begin
            @(negedge sys_clk);
            check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd1);
            check_value("udp_txen", 32'(udp_txen), 32'd0);
        end
        @(posedge sys_clk);
        fd_udp_tx <= 1'b1;
        @(negedge sys_clk);
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd1);
        @(posedge sys_clk);
        fd_udp_tx <= 1'b0;
        @(negedge sys_clk);
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd0);
        check_value("lec", 32'(lec), 32'd0);

        lec_cycles = 0;
        @(negedge sys_clk);
        while (lec) begin
            lec_cycles++;
            if (lec_cycles > LED_HOLD + WAIT_LIMIT) begin
                stop_on_timeout("end of lec");
            end
            @(negedge sys_clk);
        end
        check_value("lec cycles", 32'(lec_cycles), 32'(LED_HOLD));
        check_value("led", 32'(led), 32'(len & 15));
        finish_test($sformatf("echo length %0d", len));
    endtask

    initial begin
        int i;
        int len;
        bit poke;

        rng_state       = 32'hd8640cca;
        rst             = 1'b1;
        fs_udp_rx       = 1'b0;
        udp_rx_len      = '0;
        flag_udp_tx_req = 1'b0;
        fd_udp_tx       = 1'b0;
        for (i = 0; i < 2048; i++) begin
            // pattern spans all 11 address bits
            rx_buf[udp_echo_frame_pkg::ADDR_W'(i)] = 8'(i) ^ {5'b10110, 3'(i >> 8)};
        end
        repeat (3) @(posedge sys_clk);
        rst <= 1'b0;

        start_test();
        @(negedge sys_clk);
        check_value("fd_udp_rx", 32'(fd_udp_rx), 32'd0);
        check_value("fs_udp_tx", 32'(fs_udp_tx), 32'd0);
        check_value("flag_udp_tx_prep", 32'(flag_udp_tx_prep), 32'd0);
        check_value("udp_txen", 32'(udp_txen), 32'd0);
        check_value("len_err", 32'(len_err), 32'd0);
        check_value("lec", 32'(lec), 32'd0);
        check_value("led", 32'(led), 32'd0);
        finish_test("reset state");

        reject_bad_length(0);
        echo_datagram(1, 1'b1);
        echo_datagram(MAX_PAYLOAD, 1'b0);
        reject_bad_length(MAX_PAYLOAD + 1);
        repeat (8) begin
            len  = 1 + rand_below(MAX_PAYLOAD);
            poke = (rand_below(2) == 1);
            echo_datagram(len, poke);
        end
        len = MAX_PAYLOAD + 1 + rand_below(65535 - MAX_PAYLOAD);
        reject_bad_length(len);

        $display("summary: %0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : udp_echo_tb

`default_nettype wire

// ==== udp_echo.f ====
logic/udp_echo_frame_pkg.sv
logic/udp_echo_ctrl_pkg.sv
logic/payload_fifo.sv
logic/byte_counter.sv
logic/echo_ctrl.sv
logic/payload_loader.sv
logic/payload_sender.sv
logic/activity_led.sv
logic/udp_echo_top.sv
verif/udp_echo_tb.sv

// ==== Makefile ====
TOP := udp_echo_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f udp_echo.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
